// ==== verilog.f ====
+incdir+.
msu_bus_pkg.sv
msu_host_pkg.sv
msu_bus_sync.sv
msu_databuf.sv
msu_regs.sv
msu_host_link.sv
msu_top.sv
tb_msu.sv

// ==== tb_msu.sv ====
`include "msu_defines.svh"

// Host side of one req/ack link, answers after a random delay
module host_responder #(
  parameter int W = 32
) (
  input  logic         clkin,
  input  logic         reset,
  input  logic         hold,         // Withhold ack while high
  input  logic         req,
  input  logic [W-1:0] payload,
  output logic         ack,
  output logic         got,          // One cycle per accepted request
  output logic [W-1:0] got_payload
);
  integer seed;
  int     delay;

  initial begin
    seed  = 32'h39e0;
    ack   = 1'b0;
    got   = 1'b0;
    delay = -1;
  end

  always @(posedge clkin) begin
    got <= 1'b0;
    if (reset) begin
      ack   <= 1'b0;
      delay <= -1;
    end else if (ack) begin
      if (!req) begin
        ack <= 1'b0;  // Link has dropped req
      end
    end else if (delay > 0) begin
      delay <= delay - 1;
    end else if (delay == 0) begin
      ack   <= 1'b1;
      delay <= -1;
    end else if (req && !hold) begin
      got         <= 1'b1;
      got_payload <= payload;
      delay       <= $unsigned($random(seed)) % 5;
    end
  end
endmodule

module tb_msu;
  import msu_bus_pkg::*;
  import msu_host_pkg::*;

  typedef enum {
    OP_RD, OP_WR, OP_STAT, OP_LOAD, OP_PGM,    // Stimulus
    OP_SEEK, OP_TRACK, OP_CTRL, OP_VOL, OP_LATCH, OP_IDLE, OP_HOLD
  } op_t;

  logic clkin, reset, enable;
  logic bus_rd_n, bus_wr_n;
  reg_addr_t bus_addr;
  bus_byte_t bus_wdata, bus_rdata;
  logic pgm_we, buf_load, status_we;
  logic [`MSU_BUF_AW-1:0] pgm_addr, buf_load_addr;
  bus_byte_t pgm_data, volume;
  status_bits_t status_set, status_clr;
  logic seek_req, seek_ack, track_req, track_ack, volume_latch, track_hold;
  logic seek_got, track_got;
  seek_addr_t seek_payload, seek_got_payload;
  track_t track_payload, track_got_payload;
  logic [2:0] audio_ctrl;
  logic [31:0] seek_q[$];
  logic [31:0] track_q[$];
  int vol_count = 0;

  // Stimulus table columns
  string       names[$];
  op_t         ops[$];
  logic [15:0] addrs[$];
  logic [31:0] datas[$];
  logic [31:0] exps[$];

  msu_top dut_i (.*);

  host_responder #(.W(32)) seek_host (
    .clkin, .reset, .hold(1'b0), .req(seek_req), .payload(seek_payload),
    .ack(seek_ack), .got(seek_got), .got_payload(seek_got_payload)
  );

  host_responder #(.W(16)) track_host (
    .clkin, .reset, .hold(track_hold), .req(track_req), .payload(track_payload),
    .ack(track_ack), .got(track_got), .got_payload(track_got_payload)
  );

  initial begin
    clkin = 1'b0;
    forever #5 clkin = ~clkin;
  end

  // Record what the host receives, count volume latch cycles
  always @(posedge clkin) begin
    if (seek_got) seek_q.push_back(seek_got_payload);
    if (track_got) track_q.push_back({16'h0, track_got_payload});
    if (!reset && volume_latch) vol_count <= vol_count + 1;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s expected %0h actual %0h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input string name, input op_t op, input logic [15:0] addr,
                         input logic [31:0] data, input logic [31:0] exp);
    names.push_back(name);
    ops.push_back(op);
    addrs.push_back(addr);
    datas.push_back(data);
    exps.push_back(exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and host port drivers
  ////////////////////////////////////////////////////////////////////////////
  task automatic bus_read(input logic [2:0] addr, output bus_byte_t data);
    @(posedge clkin);
    bus_addr <= reg_addr_t'(addr);
    bus_rd_n <= 1'b0;
    repeat (6) @(posedge clkin);  // rdata valid after 4
    data = bus_rdata;
    bus_rd_n <= 1'b1;
    repeat (6) @(posedge clkin);
  endtask

  task automatic bus_write(input logic [2:0] addr, input bus_byte_t data);
    @(posedge clkin);
    bus_addr  <= reg_addr_t'(addr);
    bus_wdata <= data;
    bus_wr_n  <= 1'b0;
    repeat (6) @(posedge clkin);
    bus_wr_n <= 1'b1;
    repeat (6) @(posedge clkin);  // Write lands 4 clocks after wr_n rises
  endtask

  task automatic host_pulse(input logic [31:0] data, input logic [15:0] addr, input op_t op);
    @(posedge clkin);
    case (op)
      OP_STAT: begin
        status_set <= data[5:0];
        status_clr <= data[13:8];
        status_we  <= 1'b1;
      end
      OP_LOAD: begin
        buf_load_addr <= addr[`MSU_BUF_AW-1:0];
        buf_load      <= 1'b1;
      end
      default: begin
        pgm_addr <= addr[`MSU_BUF_AW-1:0];
        pgm_data <= data[7:0];
        pgm_we   <= 1'b1;
      end
    endcase
    repeat (4) @(posedge clkin);
    status_we <= 1'b0;
    buf_load  <= 1'b0;
    pgm_we    <= 1'b0;
    repeat (4) @(posedge clkin);
  endtask

  // Next payload that the host took from a link
  task automatic wait_host(input bit is_seek, output logic [31:0] value);
    int n;
    n = 0;
    while ((is_seek ? seek_q.size() : track_q.size()) == 0) begin
      if (n == 200) begin
        $display("timeout waiting for a %s request at the host", is_seek ? "seek" : "track");
        $display("** FAIL **");
        $fatal(1, "timeout");
      end
      @(posedge clkin);
      n++;
    end
    value = is_seek ? seek_q.pop_front() : track_q.pop_front();
  endtask

  task automatic apply_row(input int i);
    bus_byte_t   rd;
    logic [31:0] value;
    case (ops[i])
      OP_RD: begin
        bus_read(addrs[i][2:0], rd);
        check(names[i], exps[i], {24'h0, rd});
      end
      OP_WR:    bus_write(addrs[i][2:0], datas[i][7:0]);
      OP_SEEK, OP_TRACK: begin
        wait_host(ops[i] == OP_SEEK, value);
        check(names[i], exps[i], value);
      end
      OP_CTRL:  check(names[i], exps[i], {29'h0, audio_ctrl});
      OP_VOL:   check(names[i], exps[i], {24'h0, volume});
      OP_LATCH: check(names[i], exps[i], vol_count);
      OP_IDLE:  check(names[i], exps[i], {30'h0, seek_req, track_req});
      OP_HOLD: begin
        @(posedge clkin);
        track_hold <= datas[i][0];
      end
      default:  host_pulse(datas[i], addrs[i], ops[i]);
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    reset = 1'b1;
    enable = 1'b1;
    bus_rd_n = 1'b1;
    bus_wr_n = 1'b1;
    bus_addr = REG_STATUS_SEEK0;
    bus_wdata = '0;
    pgm_we = 1'b0;
    pgm_addr = '0;
    pgm_data = '0;
    buf_load = 1'b0;
    buf_load_addr = '0;
    status_we = 1'b0;
    status_set = '0;
    status_clr = '0;
    track_hold = 1'b0;

    add_row("no_req_reset", OP_IDLE,  0, 0, 0);
    add_row("status_reset", OP_RD,    0, 0, 8'hc2);  // Both busy, revision 2
    add_row("ctrl_reset",   OP_CTRL,  0, 0, 0);
    add_row("vol_reset",    OP_VOL,   0, 0, 0);
    add_row("id_s",         OP_RD,    2, 0, 8'h53);
    add_row("id_dash",      OP_RD,    3, 0, 8'h2d);
    add_row("id_m",         OP_RD,    4, 0, 8'h4d);
    add_row("id_s2",        OP_RD,    5, 0, 8'h53);
    add_row("id_u",         OP_RD,    6, 0, 8'h55);
    add_row("id_1",         OP_RD,    7, 0, 8'h31);
    add_row("clr_data_pre", OP_STAT,  0, 16'h1000, 0);  // Seek must raise data busy again
    add_row("seek_b0",      OP_WR,    0, 8'h78, 0);
    add_row("seek_b1",      OP_WR,    1, 8'h56, 0);
    add_row("seek_b2",      OP_WR,    2, 8'h34, 0);
    add_row("seek_b3",      OP_WR,    3, 8'h12, 0);
    add_row("seek_payload", OP_SEEK,  0, 0, 32'h12345678);
    add_row("seek_busy",    OP_RD,    0, 0, 8'hc2);
    add_row("clr_data",     OP_STAT,  0, 16'h1000, 0);
    add_row("seek_done",    OP_RD,    0, 0, 8'h42);
    add_row("pgm_0",        OP_PGM,   16'h0100, 8'ha1, 0);
    add_row("pgm_1",        OP_PGM,   16'h0101, 8'hb2, 0);
    add_row("pgm_2",        OP_PGM,   16'h0102, 8'hc3, 0);
    add_row("load_0",       OP_LOAD,  16'h0100, 0, 0);
    add_row("data_0",       OP_RD,    1, 0, 8'ha1);
    add_row("data_1",       OP_RD,    1, 0, 8'hb2);
    add_row("data_2",       OP_RD,    1, 0, 8'hc3);
    add_row("load_1",       OP_LOAD,  16'h0101, 0, 0);
    add_row("data_reload",  OP_RD,    1, 0, 8'hb2);
    add_row("track_b0",     OP_WR,    4, 8'h07, 0);
    add_row("track_b1",     OP_WR,    5, 8'h02, 0);
    add_row("track_payload", OP_TRACK, 0, 0, 16'h0207);
    add_row("ctrl_busy_wr", OP_WR,    7, 8'h05, 0);
    add_row("ctrl_ignored", OP_CTRL,  0, 0, 0);
    add_row("clr_audio",    OP_STAT,  0, 16'h2000, 0);
    add_row("ctrl_wr",      OP_WR,    7, 8'h05, 0);
    add_row("ctrl_taken",   OP_CTRL,  0, 0, 3'd5);
    add_row("set_err_stat", OP_STAT,  0, 16'h000e, 0);
    add_row("status_err",   OP_RD,    0, 0, 8'h3a);
    add_row("vol_wr_a",     OP_WR,    6, 8'h9c, 0);
    add_row("vol_a",        OP_VOL,   0, 0, 8'h9c);
    add_row("latch_a",      OP_LATCH, 0, 0, 1);
    add_row("vol_wr_b",     OP_WR,    6, 8'h40, 0);
    add_row("vol_b",        OP_VOL,   0, 0, 8'h40);
    add_row("latch_b",      OP_LATCH, 0, 0, 2);
    add_row("hold_ack",     OP_HOLD,  0, 1, 0);
    add_row("bp_b0",        OP_WR,    4, 8'h11, 0);
    add_row("bp_first",     OP_WR,    5, 8'h21, 0);  // Goes out at once
    add_row("bp_second",    OP_WR,    5, 8'h22, 0);  // Pending
    add_row("bp_third",     OP_WR,    5, 8'h23, 0);  // Replaces pending
    add_row("release_ack",  OP_HOLD,  0, 0, 0);
    add_row("bp_req_a",     OP_TRACK, 0, 0, 16'h2111);
    add_row("bp_req_b",     OP_TRACK, 0, 0, 16'h2311);

    repeat (16) @(posedge clkin);
    reset <= 1'b0;
    repeat (2) @(posedge clkin);
    for (int i = 0; i < names.size(); i++) begin
      apply_row(i);
    end
    $display("** PASS **");
    $finish;
  end
endmodule

// ==== msu_top.sv ====
`include "msu_defines.svh"

module msu_top (
  input  logic                       clkin,
  input  logic                       reset,
  input  logic                       bus_rd_n,
  input  logic                       bus_wr_n,
  input  msu_bus_pkg::reg_addr_t     bus_addr,
  input  msu_bus_pkg::bus_byte_t     bus_wdata,
  output msu_bus_pkg::bus_byte_t     bus_rdata,
  input  logic                       enable,
  input  logic                       pgm_we,
  input  logic [`MSU_BUF_AW-1:0]     pgm_addr,
  input  msu_bus_pkg::bus_byte_t     pgm_data,
  input  logic                       buf_load,
  input  logic [`MSU_BUF_AW-1:0]     buf_load_addr,
  input  logic                       status_we,
  input  msu_host_pkg::status_bits_t status_set,
  input  msu_host_pkg::status_bits_t status_clr,
  output logic                       seek_req,
  output msu_host_pkg::seek_addr_t   seek_payload,
  input  logic                       seek_ack,
  output logic                       track_req,
  output msu_host_pkg::track_t       track_payload,
  input  logic                       track_ack,
  output msu_bus_pkg::bus_byte_t     volume,
  output logic                       volume_latch,
  output logic [2:0]                 audio_ctrl
);
  import msu_bus_pkg::*;
  import msu_host_pkg::*;

  logic                   rd_start, rd_end, wr_end;
  reg_addr_t              reg_addr;
  bus_byte_t              wdata;
  logic [`MSU_BUF_AW-1:0] buf_rd_addr;
  bus_byte_t              buf_rd_data;
  logic                   seek_start, track_start;
  seek_addr_t             seek_addr;
  track_t                 track;

  msu_bus_sync u_bus_sync (
    .clkin, .reset, .bus_rd_n, .bus_wr_n, .bus_addr, .bus_wdata,
    .rd_start, .rd_end, .wr_end, .reg_addr, .wdata
  );

  msu_databuf u_databuf (
    .clkin, .pgm_we, .pgm_addr, .pgm_data, .rd_addr(buf_rd_addr), .rd_data(buf_rd_data)
  );

  msu_regs u_regs (
    .clkin, .reset, .enable, .rd_start, .rd_end, .wr_end, .reg_addr, .wdata,
    .rdata(bus_rdata), .buf_rd_addr, .buf_rd_data, .buf_load, .buf_load_addr,
    .status_we, .status_set, .status_clr, .seek_start, .track_start,
    .seek_addr, .track, .volume, .volume_latch, .audio_ctrl
  );

  // Seek and track commands to the host
  msu_host_link #(.payload_t(seek_addr_t)) u_seek_link (
    .clkin, .reset, .start(seek_start), .payload(seek_addr),
    .req(seek_req), .req_payload(seek_payload), .ack(seek_ack)
  );

  msu_host_link #(.payload_t(track_t)) u_track_link (
    .clkin, .reset, .start(track_start), .payload(track),
    .req(track_req), .req_payload(track_payload), .ack(track_ack)
  );

endmodule

// ==== msu_host_link.sv ====
module msu_host_link #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clkin,
  input  logic     reset,
  input  logic     start,
  input  payload_t payload,
  output logic     req,
  output payload_t req_payload,
  input  logic     ack
);

  typedef enum logic [1:0] {
    S_IDLE,  // No transfer
    S_REQ,   // req high, waiting for ack
    S_WAIT,  // req dropped, waiting for ack low
    S_LOAD   // Pending command goes out
  } state_t;

  state_t   state;
  logic     pend_valid;
  payload_t pend_payload;

  always_ff @(posedge clkin) begin
    if (reset) begin
      state      <= S_IDLE;
      req        <= 1'b0;
      pend_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            req_payload <= payload;
            req         <= 1'b1;
            state       <= S_REQ;
          end
        end
        S_REQ: begin
          if (ack) begin
            req   <= 1'b0;
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (!ack) begin
            // A start in this cycle also lands in the pending slot
            state <= (pend_valid || start) ? S_LOAD : S_IDLE;
          end
        end
        S_LOAD: begin
          req_payload <= pend_payload;
          req         <= 1'b1;
          pend_valid  <= 1'b0;
          state       <= S_REQ;
        end
      endcase
      // Busy link keeps only the newest command
      if (start && state != S_IDLE) begin
        pend_valid   <= 1'b1;
        pend_payload <= payload;
      end
    end
  end

  a_req_fall: assert property (@(posedge clkin) disable iff (reset) $fell(req) |-> $past(ack));
  a_payload_stable: assert property (@(posedge clkin) disable iff (reset)
    (req && $past(req)) |-> $stable(req_payload));

endmodule

// ==== msu_regs.sv ====
`include "msu_defines.svh"

module msu_regs (
  input  logic                       clkin,
  input  logic                       reset,
  input  logic                       enable,
  input  logic                       rd_start,
  input  logic                       rd_end,
  input  logic                       wr_end,
  input  msu_bus_pkg::reg_addr_t     reg_addr,
  input  msu_bus_pkg::bus_byte_t     wdata,
  output msu_bus_pkg::bus_byte_t     rdata,
  output logic [`MSU_BUF_AW-1:0]     buf_rd_addr,
  input  msu_bus_pkg::bus_byte_t     buf_rd_data,
  input  logic                       buf_load,
  input  logic [`MSU_BUF_AW-1:0]     buf_load_addr,
  input  logic                       status_we,
  input  msu_host_pkg::status_bits_t status_set,
  input  msu_host_pkg::status_bits_t status_clr,
  output logic                       seek_start,
  output logic                       track_start,
  output msu_host_pkg::seek_addr_t   seek_addr,
  output msu_host_pkg::track_t       track,
  output msu_bus_pkg::bus_byte_t     volume,
  output logic                       volume_latch,
  output logic [2:0]                 audio_ctrl
);
  import msu_bus_pkg::*;
  import msu_host_pkg::*;

  logic                   data_busy;
  logic                   audio_busy;
  logic                   audio_error;
  logic [1:0]             audio_status;
  logic [`MSU_BUF_AW-1:0] data_ptr;
  logic [1:0]             status_we_q;
  logic [2:0]             buf_load_q;
  logic                   status_en;
  logic                   buf_load_en;
  logic                   rd_go;
  logic                   wr_go;

  assign rd_go       = rd_start & enable;
  assign wr_go       = wr_end & enable;
  assign status_en   = (status_we_q == 2'b01);     // Rising edge of status_we
  assign buf_load_en = (buf_load_q[2:1] == 2'b01);
  assign buf_rd_addr = data_ptr;

  ////////////////////////////////////////////////////////////////////////////
  // Host strobes and data port pointer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (reset) begin
      status_we_q <= '0;
      buf_load_q  <= '0;
      data_ptr    <= '0;
    end else begin
      status_we_q <= {status_we_q[0], status_we};
      buf_load_q  <= {buf_load_q[1:0], buf_load};
      if (buf_load_en) begin
        data_ptr <= buf_load_addr;
      end else if (rd_end && enable && reg_addr == REG_DATA_SEEK1) begin
        data_ptr <= data_ptr + 1'b1;  // Advance once the read has finished
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (reset) begin
      rdata <= '0;
    end else if (rd_go) begin
      case (reg_addr)
        REG_STATUS_SEEK0: rdata <= {data_busy, audio_busy, audio_status, audio_error, `MSU_REV};
        REG_DATA_SEEK1:   rdata <= buf_rd_data;
        REG_SEEK2:        rdata <= `MSU_ID0;
        REG_SEEK3:        rdata <= `MSU_ID1;
        REG_TRACK0:       rdata <= `MSU_ID2;
        REG_TRACK1:       rdata <= `MSU_ID3;
        REG_VOLUME:       rdata <= `MSU_ID4;
        REG_CTRL:         rdata <= `MSU_ID5;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write decode and host status updates
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (reset) begin
      seek_addr    <= '0;
      track        <= '0;
      volume       <= '0;
      audio_ctrl   <= '0;
      data_busy    <= 1'b1;  // Busy until the host reports ready
      audio_busy   <= 1'b1;
      audio_error  <= 1'b0;
      audio_status <= '0;
      seek_start   <= 1'b0;
      track_start  <= 1'b0;
      volume_latch <= 1'b0;
    end else begin
      seek_start   <= 1'b0;
      track_start  <= 1'b0;
      volume_latch <= 1'b0;
      if (wr_go) begin
        case (reg_addr)
          REG_STATUS_SEEK0: seek_addr[7:0]   <= wdata;
          REG_DATA_SEEK1:   seek_addr[15:8]  <= wdata;
          REG_SEEK2:        seek_addr[23:16] <= wdata;
          REG_SEEK3: begin
            seek_addr[31:24] <= wdata;
            data_busy        <= 1'b1;
            seek_start       <= 1'b1;
          end
          REG_TRACK0: track[7:0] <= wdata;
          REG_TRACK1: begin
            track[15:8] <= wdata;
            audio_busy  <= 1'b1;
            track_start <= 1'b1;
          end
          REG_VOLUME: begin
            volume       <= wdata;
            volume_latch <= 1'b1;
          end
          REG_CTRL: begin
            if (!audio_busy) begin  // Ignored during a track load
              audio_ctrl <= wdata[2:0];
            end
          end
        endcase
      end else if (status_en) begin
        audio_busy   <= (audio_busy | status_set[ST_AUDIO_BUSY]) & ~status_clr[ST_AUDIO_BUSY];
        data_busy    <= (data_busy | status_set[ST_DATA_BUSY]) & ~status_clr[ST_DATA_BUSY];
        audio_error  <= (audio_error | status_set[ST_AUDIO_ERR]) & ~status_clr[ST_AUDIO_ERR];
        audio_status <= (audio_status | status_set[ST_AUDIO_STAT_HI:ST_AUDIO_STAT_LO])
                        & ~status_clr[ST_AUDIO_STAT_HI:ST_AUDIO_STAT_LO];
      end
    end
  end

  // Synchronizer never reports a read start and a write end together
  a_no_rd_wr: assert property (@(posedge clkin) disable iff (reset) !(rd_start && wr_end));

endmodule

// ==== msu_databuf.sv ====
`include "msu_defines.svh"

module msu_databuf (
  input  logic                   clkin,
  input  logic                   pgm_we,
  input  logic [`MSU_BUF_AW-1:0] pgm_addr,
  input  msu_bus_pkg::bus_byte_t pgm_data,
  input  logic [`MSU_BUF_AW-1:0] rd_addr,
  output msu_bus_pkg::bus_byte_t rd_data
);
  import msu_bus_pkg::*;

  localparam int DEPTH = 2 ** `MSU_BUF_AW;

  bus_byte_t mem [DEPTH];

  // Host side write port
  always_ff @(posedge clkin) begin
    if (pgm_we) begin
      mem[pgm_addr] <= pgm_data;
    end
  end

  // Data port side, registered read
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== msu_bus_sync.sv ====
module msu_bus_sync (
  input  logic                   clkin,
  input  logic                   reset,
  input  logic                   bus_rd_n,
  input  logic                   bus_wr_n,
  input  msu_bus_pkg::reg_addr_t bus_addr,
  input  msu_bus_pkg::bus_byte_t bus_wdata,
  output logic                   rd_start,
  output logic                   rd_end,
  output logic                   wr_end,
  output msu_bus_pkg::reg_addr_t reg_addr,
  output msu_bus_pkg::bus_byte_t wdata
);
  import msu_bus_pkg::*;

  logic [2:0] rd_sr;  // [1:0] sync stages, [2] edge register
  logic [2:0] wr_sr;
  reg_addr_t  addr_q1, addr_q2;
  bus_byte_t  data_q1, data_q2;

  // Strobes idle high, so reset to ones to avoid a false edge
  always_ff @(posedge clkin) begin
    if (reset) begin
      rd_sr    <= 3'b111;
      wr_sr    <= 3'b111;
      rd_start <= 1'b0;
      rd_end   <= 1'b0;
      wr_end   <= 1'b0;
    end else begin
      rd_sr    <= {rd_sr[1:0], bus_rd_n};
      wr_sr    <= {wr_sr[1:0], bus_wr_n};
      rd_start <= rd_sr[2] & ~rd_sr[1];  // rd_n falling
      rd_end   <= ~rd_sr[2] & rd_sr[1];  // rd_n rising
      wr_end   <= ~wr_sr[2] & wr_sr[1];  // wr_n rising
    end
  end

  // Address and data follow the strobes through the same two stages
  always_ff @(posedge clkin) begin
    addr_q1 <= bus_addr;
    addr_q2 <= addr_q1;
    data_q1 <= bus_wdata;
    data_q2 <= data_q1;
    if (!rd_sr[1] || !wr_sr[1]) begin  // Only sample while a strobe is active
      reg_addr <= addr_q2;
      wdata    <= data_q2;
    end
  end

  a_rd_start_one: assert property (@(posedge clkin) disable iff (reset) rd_start |=> !rd_start);
  a_rd_end_one:   assert property (@(posedge clkin) disable iff (reset) rd_end |=> !rd_end);
  a_wr_end_one:   assert property (@(posedge clkin) disable iff (reset) wr_end |=> !wr_end);

endmodule

// ==== msu_host_pkg.sv ====
package msu_host_pkg;

  // Seek target, byte address in the data file
  typedef logic [31:0] seek_addr_t;

  // Audio track number
  typedef logic [15:0] track_t;

  // Host set/clear vector for the status flags
  typedef logic [5:0] status_bits_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bit positions inside status_bits_t
  ////////////////////////////////////////////////////////////////////////////
  localparam int ST_AUDIO_BUSY    = 5;
  localparam int ST_DATA_BUSY     = 4;
  localparam int ST_AUDIO_ERR     = 3;
  localparam int ST_AUDIO_STAT_HI = 2;  // Audio status field 2:1
  localparam int ST_AUDIO_STAT_LO = 1;
  localparam int ST_CTRL_START    = 0;

endpackage

// ==== msu_bus_pkg.sv ====
package msu_bus_pkg;

  // One byte on the console data bus
  typedef logic [7:0] bus_byte_t;

  // Register index as seen from the console
  typedef enum logic [2:0] {
    REG_STATUS_SEEK0 = 3'd0,  // Read status, write seek byte 0
    REG_DATA_SEEK1   = 3'd1,  // Read data port, write seek byte 1
    REG_SEEK2        = 3'd2,
    REG_SEEK3        = 3'd3,  // Write starts the seek
    REG_TRACK0       = 3'd4,
    REG_TRACK1       = 3'd5,  // Write starts the track
    REG_VOLUME       = 3'd6,
    REG_CTRL         = 3'd7
  } reg_addr_t;

endpackage

// ==== msu_defines.svh ====
`ifndef MSU_DEFINES_SVH
`define MSU_DEFINES_SVH

// Buffer and data port pointer width
`define MSU_BUF_AW 14

////////////////////////////////////////////////////////////////////////////
// ID string "S-MSU1", registers 2 to 7
////////////////////////////////////////////////////////////////////////////
`define MSU_ID0 8'h53  // S
`define MSU_ID1 8'h2d  // -
`define MSU_ID2 8'h4d  // M
`define MSU_ID3 8'h53  // S
`define MSU_ID4 8'h55  // U
`define MSU_ID5 8'h31  // 1

// Revision in the low bits of the status byte
`define MSU_REV 3'd2

`endif
